/* airass_shell.f */
src/shell_pkg.sv
src/ioctl_if.sv
src/shell_control.sv
src/rom_word_packer.sv
src/conf_str_rom.sv
src/player_input_map.sv
src/audio_dac.sv
src/airass_shell.sv
sim/tb_mem_responder.sv
sim/airass_shell_tb.sv

/* sim/airass_shell_tb.sv */
`timescale 1ns/1ps

module airass_shell_tb;

	localparam int clk_period = 20;
	localparam int max_ack_delay = 4;
	localparam int max_bytes = 39;
	// Worst case per byte includes a full handshake with both delays
	localparam int test_cycles = 8 + 2 * max_bytes * (2 * max_ack_delay + 8) + 400 + 4200;

	logic CLK_40M = 1'b0;
	logic reset_i;
	logic ioctl_download_i;
	logic ioctl_wr_i;
	logic [7:0] ioctl_index_i;
	logic [24:0] ioctl_addr_i;
	logic [7:0] ioctl_data_i;
	logic ioctl_wait_o;
	logic mem_req_o;
	logic [23:0] mem_addr_o;
	logic [15:0] mem_data_o;
	logic [1:0] mem_be_o;
	logic mem_ack_i;
	logic [31:0] status_i;
	logic button_reset_i;
	logic core_reset_o;
	logic pause_o;
	logic [9:0] conf_addr_i;
	logic [7:0] conf_chr_o;
	logic [15:0] joy0_i;
	logic [15:0] joy1_i;
	logic [9:0] p1_o;
	logic [9:0] p2_o;
	logic [1:0] coin_o;
	logic [1:0] start_o;
	logic [15:0] audio_l_i;
	logic [15:0] audio_r_i;
	logic audio_l_o;
	logic audio_r_o;

	// Reference models, one cycle behind the inputs
	logic [7:0] exp_chr;
	logic [9:0] exp_p1;
	logic [9:0] exp_p2;
	logic [1:0] exp_coin;
	logic [1:0] exp_start;
	logic exp_pause;
	logic foreign_phase;
	logic [7:0] rom_bytes [$];
	int ones_l;
	int ones_r;

	string conf_ref = {"AIRASS;;O3,Rotate Controls,Off,On;O6,Swap Joystick,Off,On;",
		"O8,Pause,Off,On;T0,Reset;V,v1.0"};

	always #(clk_period / 2) CLK_40M = ~CLK_40M;

	airass_shell i_airass_shell (.*);

	tb_mem_responder #(.max_delay(max_ack_delay)) i_mem (
		.CLK_40M(CLK_40M),
		.reset_i(reset_i),
		.req_i(mem_req_o),
		.addr_i(mem_addr_o),
		.data_i(mem_data_o),
		.be_i(mem_be_o),
		.ack_o(mem_ack_i)
	);

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
		$display("CHECK FAILED: %s got 0x%0h expected 0x%0h", name, got, exp);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	task automatic report_failure(string what);
		$display("Error: %s", what);
		$display("Simulation failed");
		$fatal(1, "stopping at the first error");
	endtask

	function automatic logic [7:0] ref_chr(logic [9:0] a);
		if (a < conf_ref.len()) begin
			return conf_ref[a];
		end
		return 8'h00;
	endfunction

	// Clockwise turn of the four directions, fire bits pass through
	function automatic logic [9:0] ref_player(logic [15:0] joy, logic rot);
		logic [9:0] p;
		p = joy[9:0];
		if (rot) begin
			p[0] = joy[3];
			p[1] = joy[2];
			p[2] = joy[0];
			p[3] = joy[1];
		end
		return p;
	endfunction

	always_ff @(posedge CLK_40M) begin
		exp_chr <= ref_chr(conf_addr_i);
		if (reset_i) begin
			exp_p1 <= '0;
			exp_p2 <= '0;
			exp_coin <= 2'b00;
			exp_start <= 2'b00;
			exp_pause <= 1'b0;
		end else begin
			exp_p1 <= ref_player(status_i[6] ? joy1_i : joy0_i, status_i[3]);
			exp_p2 <= ref_player(status_i[6] ? joy0_i : joy1_i, status_i[3]);
			exp_coin <= status_i[6] ? {joy0_i[11], joy1_i[11]} : {joy1_i[11], joy0_i[11]};
			exp_start <= status_i[6] ? {joy0_i[10], joy1_i[10]} : {joy1_i[10], joy0_i[10]};
			exp_pause <= status_i[8];
		end
	end

	a_reset_hold: assert property (@(posedge CLK_40M) reset_i |=> core_reset_o)
		else report_mismatch("core_reset_o", $sampled(core_reset_o), 1);
	a_after_reset: assert property (@(posedge CLK_40M)
		$fell(reset_i) |-> !mem_req_o && !ioctl_wait_o && !pause_o && core_reset_o)
		else report_failure("control outputs not in their reset state after reset");
	a_download_hold: assert property (@(posedge CLK_40M) disable iff (reset_i)
		ioctl_download_i |=> core_reset_o)
		else report_mismatch("core_reset_o", $sampled(core_reset_o), 1);
	a_release: assert property (@(posedge CLK_40M) disable iff (reset_i)
		$fell(ioctl_download_i) && !status_i[0] && !button_reset_i |-> ##[0:2] !core_reset_o)
		else report_failure("core_reset_o did not fall within two cycles after download ended");
	a_status_reset: assert property (@(posedge CLK_40M) disable iff (reset_i)
		status_i[0] |=> core_reset_o)
		else report_mismatch("core_reset_o", $sampled(core_reset_o), 1);
	a_pause: assert property (@(posedge CLK_40M) disable iff (reset_i) pause_o == exp_pause)
		else report_mismatch("pause_o", $sampled(pause_o), $sampled(exp_pause));
	a_conf: assert property (@(posedge CLK_40M) disable iff (reset_i) conf_chr_o == exp_chr)
		else report_mismatch("conf_chr_o", $sampled(conf_chr_o), $sampled(exp_chr));
	a_p1: assert property (@(posedge CLK_40M) disable iff (reset_i) p1_o == exp_p1)
		else report_mismatch("p1_o", $sampled(p1_o), $sampled(exp_p1));
	a_p2: assert property (@(posedge CLK_40M) disable iff (reset_i) p2_o == exp_p2)
		else report_mismatch("p2_o", $sampled(p2_o), $sampled(exp_p2));
	a_coin: assert property (@(posedge CLK_40M) disable iff (reset_i) coin_o == exp_coin)
		else report_mismatch("coin_o", $sampled(coin_o), $sampled(exp_coin));
	a_start: assert property (@(posedge CLK_40M) disable iff (reset_i) start_o == exp_start)
		else report_mismatch("start_o", $sampled(start_o), $sampled(exp_start));
	a_no_foreign_write: assert property (@(posedge CLK_40M) foreign_phase |-> !mem_req_o)
		else report_failure("memory write started for a download at another index");

	task automatic step();
		@(posedge CLK_40M);
		#2;
	endtask

	task automatic send_byte(logic [7:0] index, logic [24:0] addr, logic [7:0] data);
		ioctl_index_i = index;
		ioctl_addr_i = addr;
		ioctl_data_i = data;
		ioctl_wr_i = 1'b1;
		step();
		ioctl_wr_i = 1'b0;
		while (ioctl_wait_o) begin
			step();
		end
	endtask

	task automatic download(logic [7:0] index, int n);
		logic [7:0] b;
		ioctl_download_i = 1'b1;
		step();
		for (int i = 0; i < n; i++) begin
			b = 8'($urandom);
			if (index == 8'd0) begin
				rom_bytes.push_back(b);
			end
			send_byte(index, 25'(i), b);
		end
		ioctl_download_i = 1'b0;
		// Lone low byte is flushed after download falls
		step();
		while (ioctl_wait_o) begin
			step();
		end
		repeat (4) step();
	endtask

	task automatic check_store();
		int n;
		logic [15:0] exp;
		n = rom_bytes.size();
		for (int k = 0; k < n / 2; k++) begin
			exp = {rom_bytes[2 * k + 1], rom_bytes[2 * k]};
			assert (i_mem.words[k] == exp) else report_mismatch("mem word", i_mem.words[k], exp);
			assert (i_mem.bes[k] == 2'b11) else report_mismatch("mem_be_o", i_mem.bes[k], 2'b11);
		end
		assert (i_mem.words[n / 2][7:0] == rom_bytes[n - 1])
			else report_mismatch("last mem word", i_mem.words[n / 2], rom_bytes[n - 1]);
		assert (i_mem.bes[n / 2] == 2'b01) else report_mismatch("mem_be_o", i_mem.bes[n / 2], 2'b01);
	endtask

	// Watchdog
	initial begin
		#(2 * test_cycles * clk_period);
		$display("Timeout: the tests did not finish in the expected time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		int writes_before;
		void'($urandom(32'hb638));
		reset_i = 1'b1;
		ioctl_download_i = 1'b0;
		ioctl_wr_i = 1'b0;
		ioctl_index_i = '0;
		ioctl_addr_i = '0;
		ioctl_data_i = '0;
		status_i = '0;
		button_reset_i = 1'b0;
		conf_addr_i = '0;
		joy0_i = '0;
		joy1_i = '0;
		foreign_phase = 1'b0;
		audio_l_i = 16'($urandom);
		audio_r_i = 16'($urandom);
		repeat (8) @(posedge CLK_40M);
		#2;
		reset_i = 1'b0;

		// Audio density counted alongside the other tests
		fork
			begin
				ones_l = 0;
				ones_r = 0;
				repeat (4096) begin
					step();
					ones_l += audio_l_o;
					ones_r += audio_r_o;
				end
			end
		join_none

		download(8'd0, 2 * ($urandom % 16) + 9);
		check_store();

		writes_before = i_mem.write_count;
		foreign_phase = 1'b1;
		download(8'd5, 12);
		foreign_phase = 1'b0;
		assert (i_mem.write_count == writes_before)
			else report_mismatch("write_count", i_mem.write_count, writes_before);

		status_i[0] = 1'b1;
		repeat (3) step();
		status_i[0] = 1'b0;
		repeat (3) step();

		repeat (150) begin
			conf_addr_i = 10'($urandom % 128);
			step();
		end

		for (int combo = 0; combo < 4; combo++) begin
			status_i[3] = combo[0];
			status_i[6] = combo[1];
			repeat (20) begin
				joy0_i = 16'($urandom);
				joy1_i = 16'($urandom);
				step();
			end
		end

		repeat (8) begin
			status_i[8] = ~status_i[8];
			repeat ($urandom % 3 + 1) step();
		end

		wait fork;
		assert (ones_l == ((32'(audio_l_i ^ 16'h8000)) * 4096) / 65536)
			else report_mismatch("audio_l_o ones", ones_l, (32'(audio_l_i ^ 16'h8000)) / 16);
		assert (ones_r == ((32'(audio_r_i ^ 16'h8000)) * 4096) / 65536)
			else report_mismatch("audio_r_o ones", ones_r, (32'(audio_r_i ^ 16'h8000)) / 16);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* sim/tb_mem_responder.sv */
`timescale 1ns/1ps

module tb_mem_responder #(
	parameter int max_delay = 4
) (
	input logic CLK_40M,
	input logic reset_i,
	input logic req_i,
	input logic [shell_pkg::mem_addr_w-1:0] addr_i,
	input logic [shell_pkg::word_w-1:0] data_i,
	input logic [1:0] be_i,
	output logic ack_o
);

	// Shadow store, keyed by word address
	logic [shell_pkg::word_w-1:0] words [int];
	logic [1:0] bes [int];
	int write_count;

	initial begin
		int delay;
		ack_o = 1'b0;
		write_count = 0;
		forever begin
			@(posedge CLK_40M);
			#2;
			if (!reset_i && req_i && !ack_o) begin
				delay = $urandom % (max_delay + 1);
				repeat (delay) begin
					@(posedge CLK_40M);
					#2;
				end
				words[addr_i] = data_i;
				bes[addr_i] = be_i;
				write_count++;
				ack_o = 1'b1;
				// Hold ack until the packer lets go of req
				do begin
					@(posedge CLK_40M);
					#2;
				end while (req_i);
				delay = $urandom % (max_delay + 1);
				repeat (delay) begin
					@(posedge CLK_40M);
					#2;
				end
				ack_o = 1'b0;
			end
		end
	end

endmodule

/* src/airass_shell.sv */
`timescale 1ns/1ps

module airass_shell (
	input logic CLK_40M,
	input logic reset_i,

	input logic ioctl_download_i,
	input logic ioctl_wr_i,
	input logic [shell_pkg::byte_w-1:0] ioctl_index_i,
	input logic [shell_pkg::ioctl_addr_w-1:0] ioctl_addr_i,
	input logic [shell_pkg::byte_w-1:0] ioctl_data_i,
	output logic ioctl_wait_o,

	output logic mem_req_o,
	output logic [shell_pkg::mem_addr_w-1:0] mem_addr_o,
	output logic [shell_pkg::word_w-1:0] mem_data_o,
	output logic [1:0] mem_be_o,
	input logic mem_ack_i,

	input logic [shell_pkg::status_w-1:0] status_i,
	input logic button_reset_i,
	output logic core_reset_o,
	output logic pause_o,

	input logic [shell_pkg::conf_addr_w-1:0] conf_addr_i,
	output logic [shell_pkg::byte_w-1:0] conf_chr_o,

	input logic [shell_pkg::joy_w-1:0] joy0_i,
	input logic [shell_pkg::joy_w-1:0] joy1_i,
	output logic [shell_pkg::player_w-1:0] p1_o,
	output logic [shell_pkg::player_w-1:0] p2_o,
	output logic [1:0] coin_o,
	output logic [1:0] start_o,

	input logic [shell_pkg::audio_w-1:0] audio_l_i,
	input logic [shell_pkg::audio_w-1:0] audio_r_i,
	output logic audio_l_o,
	output logic audio_r_o
);

	ioctl_if i_ioctl ();

	assign i_ioctl.download = ioctl_download_i;
	assign i_ioctl.wr = ioctl_wr_i;
	assign i_ioctl.index = ioctl_index_i;
	assign i_ioctl.addr = ioctl_addr_i;
	assign i_ioctl.data = ioctl_data_i;

	shell_control i_shell_control (
		.CLK_40M(CLK_40M),
		.reset_i(reset_i),
		.dl(i_ioctl.ctrl),
		.status_reset_i(status_i[shell_pkg::st_reset_bit]),
		.status_pause_i(status_i[shell_pkg::st_pause_bit]),
		.button_reset_i(button_reset_i),
		.core_reset_o(core_reset_o),
		.pause_o(pause_o)
	);

	rom_word_packer i_rom_word_packer (
		.CLK_40M(CLK_40M),
		.reset_i(reset_i),
		.dl(i_ioctl.packer),
		.mem_req_o(mem_req_o),
		.mem_addr_o(mem_addr_o),
		.mem_data_o(mem_data_o),
		.mem_be_o(mem_be_o),
		.mem_ack_i(mem_ack_i),
		.ioctl_wait_o(ioctl_wait_o)
	);

	conf_str_rom i_conf_str_rom (
		.CLK_40M(CLK_40M),
		.conf_addr_i(conf_addr_i),
		.conf_chr_o(conf_chr_o)
	);

	player_input_map i_player_input_map (
		.CLK_40M(CLK_40M),
		.reset_i(reset_i),
		.joy0_i(joy0_i),
		.joy1_i(joy1_i),
		.rotate_i(status_i[shell_pkg::st_rotate_bit]),
		.joyswap_i(status_i[shell_pkg::st_joyswap_bit]),
		.p1_o(p1_o),
		.p2_o(p2_o),
		.coin_o(coin_o),
		.start_o(start_o)
	);

	audio_dac i_dac_l (
		.CLK_40M(CLK_40M),
		.reset_i(reset_i),
		.sample_i(audio_l_i),
		.dac_o(audio_l_o)
	);

	audio_dac i_dac_r (
		.CLK_40M(CLK_40M),
		.reset_i(reset_i),
		.sample_i(audio_r_i),
		.dac_o(audio_r_o)
	);

endmodule

/* src/audio_dac.sv */
`timescale 1ns/1ps

module audio_dac (
	input logic CLK_40M,
	input logic reset_i,
	input logic [shell_pkg::audio_w-1:0] sample_i,
	output logic dac_o
);

	logic [shell_pkg::audio_w-1:0] u;
	logic [shell_pkg::audio_w-1:0] acc;
	logic [shell_pkg::audio_w:0] sum;

	// Offset binary from two's complement
	assign u = {~sample_i[shell_pkg::audio_w-1], sample_i[shell_pkg::audio_w-2:0]};

	assign sum = {1'b0, acc} + {1'b0, u};

	// Carry density equals u / 2**audio_w
	always_ff @(posedge CLK_40M) begin
		if (reset_i) begin
			acc <= '0;
			dac_o <= 1'b0;
		end else begin
			acc <= sum[shell_pkg::audio_w-1:0];
			dac_o <= sum[shell_pkg::audio_w];
		end
	end

endmodule

/* src/conf_str_rom.sv */
`timescale 1ns/1ps

module conf_str_rom (
	input logic CLK_40M,
	input logic [shell_pkg::conf_addr_w-1:0] conf_addr_i,
	output logic [shell_pkg::byte_w-1:0] conf_chr_o
);

	logic in_range;
	logic [shell_pkg::conf_addr_w-1:0] chr_pos;

	assign in_range = conf_addr_i < shell_pkg::conf_str_len;

	// Character 0 sits in the top byte of the string
	assign chr_pos = shell_pkg::conf_addr_w'(shell_pkg::conf_str_len - 1) - conf_addr_i;

	always_ff @(posedge CLK_40M) begin
		if (in_range) begin
			conf_chr_o <= shell_pkg::conf_str[chr_pos * shell_pkg::byte_w +: shell_pkg::byte_w];
		end else begin
			conf_chr_o <= '0;
		end
	end

endmodule

/* src/ioctl_if.sv */
`timescale 1ns/1ps

interface ioctl_if;

	logic download;
	logic wr;
	logic [shell_pkg::byte_w-1:0] index;
	logic [shell_pkg::ioctl_addr_w-1:0] addr;
	logic [shell_pkg::byte_w-1:0] data;

	// Reset sequencing only needs the download flag
	modport ctrl (
		input download
	);

	modport packer (
		input download,
		input wr,
		input index,
		input addr,
		input data
	);

endinterface

/* src/player_input_map.sv */
`timescale 1ns/1ps

module player_input_map (
	input logic CLK_40M,
	input logic reset_i,
	input logic [shell_pkg::joy_w-1:0] joy0_i,
	input logic [shell_pkg::joy_w-1:0] joy1_i,
	input logic rotate_i,
	input logic joyswap_i,
	output logic [shell_pkg::player_w-1:0] p1_o,
	output logic [shell_pkg::player_w-1:0] p2_o,
	output logic [1:0] coin_o,
	output logic [1:0] start_o
);

	logic [shell_pkg::joy_w-1:0] src1;
	logic [shell_pkg::joy_w-1:0] src2;

	// Joystick bits: 0 right, 1 left, 2 down, 3 up, fire above
	function automatic logic [shell_pkg::player_w-1:0] map_player(
		input logic [shell_pkg::joy_w-1:0] joy,
		input logic rot
	);
		if (rot) begin
			// Clockwise turn, output {up, down, left, right} = {left, right, down, up}
			return {joy[shell_pkg::player_w-1:4], joy[1], joy[0], joy[2], joy[3]};
		end
		return joy[shell_pkg::player_w-1:0];
	endfunction

	assign src1 = joyswap_i ? joy1_i : joy0_i;
	assign src2 = joyswap_i ? joy0_i : joy1_i;

	always_ff @(posedge CLK_40M) begin
		if (reset_i) begin
			p1_o <= '0;
			p2_o <= '0;
			coin_o <= 2'b00;
			start_o <= 2'b00;
		end else begin
			p1_o <= map_player(src1, rotate_i);
			p2_o <= map_player(src2, rotate_i);
			coin_o <= {src2[shell_pkg::coin1_bit], src1[shell_pkg::coin1_bit]};
			start_o <= {src2[shell_pkg::start1_bit], src1[shell_pkg::start1_bit]};
		end
	end

endmodule

/* src/rom_word_packer.sv */
`timescale 1ns/1ps

module rom_word_packer (
	input logic CLK_40M,
	input logic reset_i,
	ioctl_if.packer dl,
	output logic mem_req_o,
	output logic [shell_pkg::mem_addr_w-1:0] mem_addr_o,
	output logic [shell_pkg::word_w-1:0] mem_data_o,
	output logic [1:0] mem_be_o,
	input logic mem_ack_i,
	output logic ioctl_wait_o
);

	logic [shell_pkg::byte_w-1:0] low_byte;
	logic have_low;
	logic byte_ok;
	logic start_word;
	logic start_flush;

	assign byte_ok = dl.wr & dl.download & (dl.index == shell_pkg::rom_index);

	// Odd address closes a word, a lone low byte goes out when download ends
	assign start_word = ~ioctl_wait_o & byte_ok & dl.addr[0];
	assign start_flush = ~ioctl_wait_o & ~byte_ok & have_low & ~dl.download;

	// FSM held in two flags
	// idle: wait low; request: req high; ack low wait: wait high, req low
	always_ff @(posedge CLK_40M) begin
		if (reset_i) begin
			mem_req_o <= 1'b0;
			ioctl_wait_o <= 1'b0;
			have_low <= 1'b0;
		end else if (!ioctl_wait_o) begin
			if (start_word || start_flush) begin
				mem_req_o <= 1'b1;
				ioctl_wait_o <= 1'b1;
				have_low <= 1'b0;
			end else if (byte_ok) begin
				have_low <= 1'b1;
			end
		end else if (mem_req_o) begin
			if (mem_ack_i) begin
				mem_req_o <= 1'b0;
			end
		end else if (!mem_ack_i) begin
			ioctl_wait_o <= 1'b0;
		end
	end

	// Payload only changes while idle, so it holds during req
	always_ff @(posedge CLK_40M) begin
		if (!ioctl_wait_o && byte_ok) begin
			mem_addr_o <= dl.addr[shell_pkg::ioctl_addr_w-1:1];
			if (dl.addr[0]) begin
				mem_data_o <= {dl.data, low_byte};
				mem_be_o <= 2'b11;
			end else begin
				low_byte <= dl.data;
			end
		end else if (start_flush) begin
			mem_data_o <= {{shell_pkg::byte_w{1'b0}}, low_byte};
			mem_be_o <= 2'b01;
		end
	end

	a_req_until_ack: assert property (
		@(posedge CLK_40M) disable iff (reset_i)
		$fell(mem_req_o) |-> $past(mem_ack_i)
	) else $error("mem_req_o dropped before mem_ack_i");

	a_payload_stable: assert property (
		@(posedge CLK_40M) disable iff (reset_i)
		mem_req_o && $past(mem_req_o) |->
			$stable(mem_addr_o) && $stable(mem_data_o) && $stable(mem_be_o)
	) else $error("memory payload changed during request");

endmodule

/* src/shell_control.sv */
`timescale 1ns/1ps

module shell_control (
	input logic CLK_40M,
	input logic reset_i,
	ioctl_if.ctrl dl,
	input logic status_reset_i,
	input logic status_pause_i,
	input logic button_reset_i,
	output logic core_reset_o,
	output logic pause_o
);

	logic download_d;
	logic rom_loaded;

	// Falling edge of download marks the end of the ROM transfer
	always_ff @(posedge CLK_40M) begin
		if (reset_i) begin
			download_d <= 1'b0;
			rom_loaded <= 1'b0;
		end else begin
			download_d <= dl.download;
			if (download_d && !dl.download) begin
				rom_loaded <= 1'b1;
			end
		end
	end

	// Core stays in reset while a download runs or before the first one ends
	always_ff @(posedge CLK_40M) begin
		if (reset_i) begin
			core_reset_o <= 1'b1;
			pause_o <= 1'b0;
		end else begin
			core_reset_o <= status_reset_i | button_reset_i | dl.download | ~rom_loaded;
			pause_o <= status_pause_i;
		end
	end

	// Game core must never run on a half loaded ROM
	a_reset_during_download: assert property (
		@(posedge CLK_40M) disable iff (reset_i)
		dl.download && $past(dl.download) |-> core_reset_o
	) else $error("core_reset_o low during download");

endmodule

/* src/shell_pkg.sv */
package shell_pkg;

	// Download bus and memory port
	localparam int byte_w = 8;
	localparam int word_w = 16;
	localparam int ioctl_addr_w = 25;
	localparam int mem_addr_w = 24;
	localparam logic [byte_w-1:0] rom_index = 8'd0;

	// Status word from the host menu
	localparam int status_w = 32;
	localparam int st_reset_bit = 0;
	localparam int st_rotate_bit = 3;
	localparam int st_joyswap_bit = 6;
	localparam int st_pause_bit = 8;

	// Joystick and player words
	localparam int joy_w = 16;
	localparam int start1_bit = 10;
	localparam int coin1_bit = 11;
	// Six fire bits above up, down, left, right
	localparam int player_w = 10;

	localparam int audio_w = 16;

	// Menu string, first character in the top byte
	localparam conf_str = {
		"AIRASS;;",
		"O3,Rotate Controls,Off,On;",
		"O6,Swap Joystick,Off,On;",
		"O8,Pause,Off,On;",
		"T0,Reset;",
		"V,v1.0"
	};
	localparam int conf_str_len = $bits(conf_str) / byte_w;
	localparam int conf_addr_w = 10;

endpackage
